// File: include/parse_consts.svh
`ifndef PARSE_CONSTS_SVH
`define PARSE_CONSTS_SVH

////////////////////
// feature map
////////////////////
`define PARSE_MAP_COLS 64
`define PARSE_MAP_ROWS 64 // last row is 63

////////////////////
// window timing
////////////////////
`define PARSE_WIN_DELAY 100 // window is this + 1 cycles
`define PARSE_ACC_DELAY 33
`define PARSE_SPLIT_DELAY (`PARSE_WIN_DELAY - `PARSE_ACC_DELAY)
`define PARSE_COL_SYNC 63 // pause between rows

////////////////////
// bram banks
////////////////////
`define PARSE_NUM_BANKS 16
`define PARSE_BANK_AW 9
`define PARSE_BANK_DW 128
`define PARSE_LANE_W 8
`define PARSE_ROW_BASE 64 // second row half in a bank

`endif

// File: src/parse_scan_pkg.sv
`default_nettype none

package parse_scan_pkg;

	typedef enum logic [2:0] {
		st_idle = 3'd0,
		st_row0 = 3'd1,
		st_row_odd = 3'd2,
		st_row_even = 3'd3,
		st_row_end = 3'd4,
		st_col_end = 3'd5 // sync pause at row change
	} scan_state_t;

	// group of four banks holding one row phase
	typedef logic [1:0] row_phase_t;

	typedef struct packed {
		scan_state_t state;
		logic [7:0] col;
		logic col_tgl;
		logic first_col;
		logic last_col;
		logic win_strobe; // last cycle of window
		logic split; // accumulate part of window
	} scan_pos_t;

endpackage

`default_nettype wire

// File: src/parse_bank_pkg.sv
`default_nettype none
`include "parse_consts.svh"

package parse_bank_pkg;

	typedef logic [`PARSE_BANK_AW-1:0] bank_addr_t;
	typedef logic [`PARSE_BANK_DW-1:0] bank_word_t;
	typedef logic [`PARSE_LANE_W-1:0] lane_byte_t;

	typedef bank_addr_t [`PARSE_NUM_BANKS-1:0] bank_addr_vec_t;
	typedef bank_word_t [`PARSE_NUM_BANKS-1:0] bank_word_vec_t;
	typedef lane_byte_t [`PARSE_NUM_BANKS-1:0] lane_vec_t;

	typedef logic [`PARSE_NUM_BANKS-1:0] bank_cs_t; // bit 0 is bank 0

endpackage

`default_nettype wire

// File: src/scan_fsm.sv
`timescale 1ns/1ps
`default_nettype none
`include "parse_consts.svh"

module scan_fsm (
	input  logic clk,
	input  logic rstn,
	input  logic start,
	output parse_scan_pkg::scan_pos_t pos,
	output logic col_done
);

	localparam int DLY_W = $clog2(`PARSE_WIN_DELAY + 1);
	localparam int ROW_W = $clog2(`PARSE_MAP_ROWS + 1);
	localparam int SYNC_W = $clog2(`PARSE_COL_SYNC + 2);

	parse_scan_pkg::scan_state_t state;
	parse_scan_pkg::scan_state_t state_nxt;
	parse_scan_pkg::scan_state_t prev_row; // row state just completed
	logic [7:0] col;
	logic [ROW_W-1:0] row;
	logic [DLY_W-1:0] dly_cnt;
	logic col_tgl;
	logic [SYNC_W-1:0] sync_cnt;
	logic sync_end;
	logic active;

	assign active = start && (state != parse_scan_pkg::st_idle) &&
		(state != parse_scan_pkg::st_col_end);
	assign col_done = active && (col == 8'(`PARSE_MAP_COLS));

	////////////////////
	// state
	////////////////////
	always_comb begin
		state_nxt = state;
		case (state)
			parse_scan_pkg::st_idle: begin
				if (start)
					state_nxt = parse_scan_pkg::st_row0;
			end
			parse_scan_pkg::st_row0,
			parse_scan_pkg::st_row_odd,
			parse_scan_pkg::st_row_even,
			parse_scan_pkg::st_row_end: begin
				if (col_done)
					state_nxt = parse_scan_pkg::st_col_end;
			end
			parse_scan_pkg::st_col_end: begin
				if (sync_end) begin
					if (prev_row == parse_scan_pkg::st_row_end)
						state_nxt = parse_scan_pkg::st_idle; // frame done
					else if (row == ROW_W'(`PARSE_MAP_ROWS - 1))
						state_nxt = parse_scan_pkg::st_row_end;
					else if (prev_row == parse_scan_pkg::st_row_odd)
						state_nxt = parse_scan_pkg::st_row_even;
					else
						state_nxt = parse_scan_pkg::st_row_odd;
				end
			end
			default: state_nxt = parse_scan_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state <= parse_scan_pkg::st_idle;
			prev_row <= parse_scan_pkg::st_idle;
		end else begin
			state <= state_nxt;
			if (col_done)
				prev_row <= state;
		end
	end

	////////////////////
	// column / row / window counters
	////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			col <= '0;
			row <= '0;
			dly_cnt <= '0;
			col_tgl <= 1'b0;
		end else if (state == parse_scan_pkg::st_idle) begin
			col <= '0;
			row <= '0;
			dly_cnt <= '0;
			col_tgl <= 1'b0;
		end else if (active) begin
			if (col_done) begin
				col <= '0;
				row <= row + 1'b1;
			end else if (dly_cnt == DLY_W'(`PARSE_WIN_DELAY)) begin
				dly_cnt <= '0;
				col <= col + 1'b1;
				col_tgl <= ~col_tgl;
			end else begin
				dly_cnt <= dly_cnt + 1'b1;
			end
		end
	end

	// col_end pause, leaves one cycle after count reaches sync length
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			sync_cnt <= '0;
			sync_end <= 1'b0;
		end else if (state == parse_scan_pkg::st_col_end) begin
			if (sync_end) begin
				sync_cnt <= '0;
				sync_end <= 1'b0;
			end else begin
				sync_cnt <= sync_cnt + 1'b1;
				sync_end <= (sync_cnt == SYNC_W'(`PARSE_COL_SYNC));
			end
		end
	end

	always_comb begin
		pos.state = state;
		pos.col = col;
		pos.col_tgl = col_tgl;
		pos.first_col = (col == 8'd0);
		pos.last_col = (col == 8'(`PARSE_MAP_COLS - 1));
		pos.win_strobe = active && (dly_cnt == DLY_W'(`PARSE_WIN_DELAY));
		pos.split = (dly_cnt > DLY_W'(`PARSE_SPLIT_DELAY));
	end

endmodule

`default_nettype wire

// File: src/bank_addr_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "parse_consts.svh"

module bank_addr_gen (
	input  logic clk,
	input  logic rstn,
	input  parse_scan_pkg::scan_pos_t pos,
	input  logic col_done,
	output parse_bank_pkg::bank_cs_t cs,
	output parse_bank_pkg::bank_addr_vec_t bank_addr
);

	logic odd_tgl;
	logic even_tgl;
	logic reload;
	logic [`PARSE_NUM_BANKS-1:0] base_mask; // banks reloaded to row base
	logic [`PARSE_NUM_BANKS-1:0] inc_mask;

	////////////////////
	// address reload / increment
	////////////////////
	always_comb begin
		reload = 1'b0;
		base_mask = '0;
		case (pos.state)
			parse_scan_pkg::st_row0: begin
				reload = col_done;
				base_mask = 16'h000f;
			end
			parse_scan_pkg::st_row_odd: begin
				reload = col_done;
				base_mask = odd_tgl ? 16'hf000 : 16'h0fff;
			end
			parse_scan_pkg::st_row_even: begin
				reload = col_done;
				base_mask = even_tgl ? 16'h000f : 16'hfff0;
			end
			default: ;
		endcase
	end

	assign inc_mask = pos.col_tgl ? 16'h3333 : 16'hcccc;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			bank_addr <= '0;
			odd_tgl <= 1'b0;
			even_tgl <= 1'b0;
		end else if (reload) begin
			for (int b = 0; b < `PARSE_NUM_BANKS; b++) begin
				bank_addr[b] <= base_mask[b] ?
					parse_bank_pkg::bank_addr_t'(`PARSE_ROW_BASE) : '0;
			end
			if (pos.state == parse_scan_pkg::st_row_odd)
				odd_tgl <= ~odd_tgl;
			if (pos.state == parse_scan_pkg::st_row_even)
				even_tgl <= ~even_tgl;
		end else if (pos.win_strobe && !pos.last_col) begin
			for (int b = 0; b < `PARSE_NUM_BANKS; b++) begin
				if (inc_mask[b])
					bank_addr[b] <= bank_addr[b] + 1'b1;
			end
		end
	end

	// first column skips the left neighbour bank of each phase
	always_comb begin
		case (pos.state)
			parse_scan_pkg::st_row0: cs = pos.first_col ? 16'h0777 : 16'h0fff;
			parse_scan_pkg::st_row_odd,
			parse_scan_pkg::st_row_even: cs = pos.first_col ? 16'h7777 : 16'hffff;
			parse_scan_pkg::st_row_end: cs = pos.first_col ? 16'h7770 : 16'hfff0;
			default: cs = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: src/window_slicer.sv
`timescale 1ns/1ps
`default_nettype none
`include "parse_consts.svh"

module window_slicer (
	input  logic clk,
	input  logic rstn,
	input  parse_scan_pkg::scan_pos_t pos,
	input  parse_bank_pkg::bank_word_vec_t bank_data,
	output parse_bank_pkg::lane_vec_t lane_data
);

	localparam int BYTES = `PARSE_BANK_DW / `PARSE_LANE_W;
	localparam int SEL_W = $clog2(BYTES);
	localparam int IDX_W = $clog2(BYTES + 1); // one extra idle step

	parse_bank_pkg::bank_word_vec_t word_q;
	parse_bank_pkg::lane_vec_t lane_nxt;
	parse_scan_pkg::row_phase_t phase_off;
	logic [1:0] rot;
	logic [IDX_W-1:0] slice_idx;
	logic slice_idle;
	logic active;
	logic top_pad;
	logic bot_pad;

	assign active = (pos.state != parse_scan_pkg::st_idle) &&
		(pos.state != parse_scan_pkg::st_col_end);
	assign slice_idle = (slice_idx == IDX_W'(BYTES));
	assign top_pad = (pos.state == parse_scan_pkg::st_row0);
	assign bot_pad = (pos.state == parse_scan_pkg::st_row_end);

	// bank word register
	always_ff @(posedge clk) begin
		if (active)
			word_q <= bank_data;
	end

	////////////////////
	// bank to lane mapping
	////////////////////
	always_comb begin
		if (pos.state == parse_scan_pkg::st_row_odd || bot_pad)
			phase_off = 2'd1;
		else
			phase_off = 2'd3; // row0 and even rows
		rot = pos.col_tgl ? 2'd1 : 2'd3;
	end

	always_comb begin : lane_mux
		parse_scan_pkg::row_phase_t grp_phase;
		logic [1:0] sub;
		logic pad;
		for (int l = 0; l < `PARSE_NUM_BANKS; l++) begin
			grp_phase = parse_scan_pkg::row_phase_t'(l >> 2) + phase_off;
			sub = 2'(l) + rot; // rotate inside the phase group
			pad = (pos.first_col && (l % 4 == 0)) ||
				(pos.last_col && (l % 4 == 3)) ||
				(top_pad && (l < 4)) ||
				(bot_pad && (l >= 12));
			if (pad)
				lane_nxt[l] = '0;
			else
				lane_nxt[l] = word_q[{grp_phase, sub}][slice_idx[SEL_W-1:0] *
					`PARSE_LANE_W +: `PARSE_LANE_W];
		end
	end

	////////////////////
	// lane output
	////////////////////
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			lane_data <= '0;
			slice_idx <= '0;
		end else if (pos.split) begin
			if (slice_idle) begin
				slice_idx <= '0; // hold lanes one cycle
			end else begin
				lane_data <= lane_nxt;
				slice_idx <= slice_idx + 1'b1;
			end
		end else begin
			slice_idx <= '0;
		end
	end

endmodule

`default_nettype wire

// File: src/parsing_data_layer.sv
`timescale 1ns/1ps
`default_nettype none

module parsing_data_layer (
	input  logic clk,
	input  logic rstn,
	input  logic start,
	input  parse_bank_pkg::bank_word_vec_t bank_data,
	output parse_bank_pkg::bank_cs_t cs,
	output parse_bank_pkg::bank_addr_vec_t bank_addr,
	output parse_bank_pkg::lane_vec_t lane_data,
	output logic mac_vld
);

	parse_scan_pkg::scan_pos_t pos;
	logic col_done;

	scan_fsm u_scan_fsm (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.pos(pos),
		.col_done(col_done)
	);

	bank_addr_gen u_bank_addr_gen (
		.clk(clk),
		.rstn(rstn),
		.pos(pos),
		.col_done(col_done),
		.cs(cs),
		.bank_addr(bank_addr)
	);

	window_slicer u_window_slicer (
		.clk(clk),
		.rstn(rstn),
		.pos(pos),
		.bank_data(bank_data),
		.lane_data(lane_data)
	);

	assign mac_vld = pos.split; // accumulate phase of each window

endmodule

`default_nettype wire

// File: tb/tb_parsing_data_layer.sv
`timescale 1ns/1ps
`default_nettype none
`include "parse_consts.svh"

module tb_parsing_data_layer;

	localparam int NUM_CASES = 8;
	localparam int CASE_LEN = 3 + `PARSE_NUM_BANKS; // row, col, cs, lanes
	localparam int MEM_WORDS = `PARSE_NUM_BANKS + NUM_CASES * CASE_LEN;
	localparam int WIN_LEN = `PARSE_WIN_DELAY + 1;
	localparam int VLD_LEN = `PARSE_ACC_DELAY;
	localparam int WAIT_LIMIT = 400;

	logic clk;
	logic rstn;
	logic start;
	parse_bank_pkg::bank_word_vec_t bank_data;
	parse_bank_pkg::bank_cs_t cs;
	parse_bank_pkg::bank_addr_vec_t bank_addr;
	parse_bank_pkg::lane_vec_t lane_data;
	logic mac_vld;

	logic [15:0] case_mem [0:MEM_WORDS-1];
	int err_cnt;
	int tmo_cnt;
	int cyc;
	logic hung;
	parse_bank_pkg::lane_vec_t last_lanes; // lanes on last window cycle
	parse_bank_pkg::bank_cs_t last_cs;

	parsing_data_layer u_parsing_data_layer (
		.clk(clk),
		.rstn(rstn),
		.start(start),
		.bank_data(bank_data),
		.cs(cs),
		.bank_addr(bank_addr),
		.lane_data(lane_data),
		.mac_vld(mac_vld)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cyc <= cyc + 1;

	////////////////////
	// helpers
	////////////////////
	task automatic load_cases();
		$readmemh("tb/parse_cases.txt", case_mem);
		if ($isunknown(case_mem[MEM_WORDS-1])) begin
			$display("could not read all entries of tb/parse_cases.txt");
			err_cnt++;
		end
		for (int b = 0; b < `PARSE_NUM_BANKS; b++)
			bank_data[b] = {(`PARSE_BANK_DW / `PARSE_LANE_W){case_mem[b][7:0]}};
	endtask

	task automatic check_idle_outputs();
		if (cs !== '0 || bank_addr !== '0 || lane_data !== '0 || mac_vld !== 1'b0) begin
			$display("** Error at %0t: outputs not zero before start", $time);
			err_cnt++;
		end
	endtask

	// banks in base_mask expect the row base, banks in one_mask expect 1
	task automatic check_addr(input logic [15:0] base_mask, input logic [15:0] one_mask,
		input string what);
		parse_bank_pkg::bank_addr_t exp;
		for (int b = 0; b < `PARSE_NUM_BANKS; b++) begin
			if (base_mask[b])
				exp = `PARSE_ROW_BASE;
			else if (one_mask[b])
				exp = 1;
			else
				exp = 0;
			if (bank_addr[b] !== exp) begin
				$display("** Error at %0t: bank %0d address %0d, expected %0d %s",
					$time, b, bank_addr[b], exp, what);
				err_cnt++;
			end
		end
	endtask

	task automatic check_case(input int row, input int col);
		int base;
		parse_bank_pkg::lane_vec_t exp_lanes;
		for (int i = 0; i < NUM_CASES; i++) begin
			base = `PARSE_NUM_BANKS + i * CASE_LEN;
			if (case_mem[base] == 16'(row) && case_mem[base+1] == 16'(col)) begin
				if (last_cs !== case_mem[base+2]) begin
					$display("** Error at %0t: cs %h, expected %h in row %0d column %0d",
						$time, last_cs, case_mem[base+2], row, col);
					err_cnt++;
				end
				for (int l = 0; l < `PARSE_NUM_BANKS; l++) begin
					exp_lanes[l] = case_mem[base+3+l][7:0];
					if (last_lanes[l] !== exp_lanes[l]) begin
						$display("** Error at %0t: lane %0d is %h, expected %h row %0d col %0d",
							$time, l, last_lanes[l], exp_lanes[l], row, col);
						err_cnt++;
					end
				end
			end
		end
	endtask

	task automatic run_window(input int row, input int col, inout int prev_rise);
		int n;
		int width;
		n = 0;
		while (!mac_vld && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!mac_vld) begin
			$display("timeout: mac_vld never rose in row %0d column %0d", row, col);
			tmo_cnt++;
			hung = 1'b1;
			return;
		end
		if (col > 0 && cyc - prev_rise != WIN_LEN) begin
			$display("** Error at %0t: window period %0d, expected %0d", $time,
				cyc - prev_rise, WIN_LEN);
			err_cnt++;
		end
		prev_rise = cyc;
		width = 0;
		while (mac_vld && width < 2 * VLD_LEN) begin
			last_lanes = lane_data;
			last_cs = cs;
			width++;
			@(negedge clk);
		end
		if (mac_vld) begin
			$display("timeout: mac_vld stuck high in row %0d column %0d", row, col);
			tmo_cnt++;
			hung = 1'b1;
			return;
		end
		if (width != VLD_LEN) begin
			$display("** Error at %0t: mac_vld high %0d cycles, expected %0d", $time,
				width, VLD_LEN);
			err_cnt++;
		end
		check_case(row, col);
	endtask

	// col_end pause between row 0 and row 1
	task automatic check_row_change();
		int n;
		int zeros;
		n = 0;
		while (cs !== '0 && n < 16) begin
			@(negedge clk);
			n++;
		end
		if (cs !== '0) begin
			$display("timeout: chip select never dropped after row 0");
			tmo_cnt++;
			hung = 1'b1;
			return;
		end
		zeros = 0;
		while (cs === '0 && zeros < WAIT_LIMIT) begin
			zeros++;
			@(negedge clk);
		end
		if (cs === '0) begin
			$display("timeout: chip select stayed zero after row 0");
			tmo_cnt++;
			hung = 1'b1;
			return;
		end
		if (zeros != `PARSE_COL_SYNC + 2) begin
			$display("** Error at %0t: col_end pause %0d cycles, expected %0d", $time,
				zeros, `PARSE_COL_SYNC + 2);
			err_cnt++;
		end
		if (cs !== 16'h7777) begin
			$display("** Error at %0t: cs %h at row 1 start, expected 7777", $time, cs);
			err_cnt++;
		end
		check_addr(16'h000f, 16'h0000, "at row 1 start");
	endtask

	task automatic run_frame();
		int prev_rise;
		prev_rise = 0;
		for (int r = 0; r < 2; r++) begin
			for (int c = 0; c < `PARSE_MAP_COLS; c++) begin
				run_window(r, c, prev_rise);
				if (hung)
					return;
				if (r == 0 && c == 0)
					check_addr(16'h0000, 16'hcccc, "after column 0");
				if (r == 0 && c == 1)
					check_addr(16'h0000, 16'hffff, "after column 1");
				if (r == 0 && c == `PARSE_MAP_COLS - 1) begin
					check_row_change();
					if (hung)
						return;
				end
			end
		end
	endtask

	////////////////////
	// main sequence
	////////////////////
	initial begin
		rstn = 1'b0;
		start = 1'b0;
		bank_data = '0;
		err_cnt = 0;
		tmo_cnt = 0;
		hung = 1'b0;
		load_cases();
		repeat (4) @(negedge clk);
		rstn = 1'b1;
		repeat (2) @(negedge clk);
		check_idle_outputs();
		start = 1'b1; // held for the whole frame
		run_frame();
		$display("errors: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
		if (err_cnt == 0 && tmo_cnt == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/parse_cases.txt
// fill byte of banks 0 to 15, then one checked window per line (hex)
// row col cs lane0 .. lane15
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
00 00 0777 00 00 00 00 00 40 41 42 00 44 45 46 00 48 49 4a
00 01 0fff 00 00 00 00 41 42 43 40 45 46 47 44 49 4a 4b 48
00 02 0fff 00 00 00 00 43 40 41 42 47 44 45 46 4b 48 49 4a
00 3f 0fff 00 00 00 00 41 42 43 00 45 46 47 00 49 4a 4b 00
01 00 7777 00 44 45 46 00 48 49 4a 00 4c 4d 4e 00 40 41 42
01 01 ffff 45 46 47 44 49 4a 4b 48 4d 4e 4f 4c 41 42 43 40
01 02 ffff 47 44 45 46 4b 48 49 4a 4f 4c 4d 4e 43 40 41 42
01 3f ffff 45 46 47 00 49 4a 4b 00 4d 4e 4f 00 41 42 43 00

// File: flist.f
+incdir+include
src/parse_scan_pkg.sv
src/parse_bank_pkg.sv
src/scan_fsm.sv
src/bank_addr_gen.sv
src/window_slicer.sv
src/parsing_data_layer.sv
tb/tb_parsing_data_layer.sv

// File: Bender.yml
package:
  name: parsing_data_layer

export_include_dirs:
  - include

sources:
  - files:
      - src/parse_scan_pkg.sv
      - src/parse_bank_pkg.sv
      - src/scan_fsm.sv
      - src/bank_addr_gen.sv
      - src/window_slicer.sv
      - src/parsing_data_layer.sv
  - target: test
    files:
      - tb/tb_parsing_data_layer.sv
